//--- design/pu_settings.svh
/* processing unit settings
   data width, register file size, interrupt vector and mul/div iteration count */
`ifndef PU_SETTINGS_SVH
`define PU_SETTINGS_SVH

// data and word address width
`define PU_ARCHBITSZ 32

// general purpose registers
`define PU_GPRCNT 16
`define PU_GPRIDXSZ 4

// immediate field of an instruction word
`define PU_IMMSZ 16

// word address taken on an external interrupt
`define PU_INTRVECTOR 'h100

// iterations per multiply or divide
`define PU_MULDIVCNT 32

`endif

//--- design/pu_pkg.sv
/* processing unit types
   opcodes, bus operations and sequencer states */
package pu_pkg;

	// instruction opcode, top 4 bits of the word
	typedef enum logic [3:0] {
		OP_LI    = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUB   = 4'd2,
		OP_AND   = 4'd3,
		OP_OR    = 4'd4,
		OP_XOR   = 4'd5,
		OP_SHL   = 4'd6,
		OP_SHR   = 4'd7,
		OP_MUL   = 4'd8,
		OP_DIVU  = 4'd9,
		OP_LD    = 4'd10,
		OP_ST    = 4'd11,
		OP_JZ    = 4'd12,
		OP_GETID = 4'd13,
		OP_HALT  = 4'd14,
		OP_RTI   = 4'd15
	} opcode_t;

	// bus operation on pi1
	typedef enum logic [1:0] {
		MEMNOOP    = 2'b00,
		MEMWRITEOP = 2'b01,
		MEMREADOP  = 2'b10
	} memop_t;

	typedef enum logic [2:0] {
		SEQ_FETCH,   // issue instruction read
		SEQ_FWAIT,   // wait for instruction word
		SEQ_DECODE,
		SEQ_EXEC,
		SEQ_MDWAIT,  // multiply/divide running
		SEQ_MEMWAIT, // load or store on the bus
		SEQ_HALT
	} seqstate_t;

endpackage

//--- design/pu_gpr.sv
/* general purpose register file
   sixteen words, two combinational read ports, one write port */
`include "pu_settings.svh"

module pu_gpr (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic [`PU_GPRIDXSZ-1:0]  raddr_a_i,
	input  logic [`PU_GPRIDXSZ-1:0]  raddr_b_i,
	output logic [`PU_ARCHBITSZ-1:0] rdata_a_o,
	output logic [`PU_ARCHBITSZ-1:0] rdata_b_o,
	input  logic                     we_i,
	input  logic [`PU_GPRIDXSZ-1:0]  waddr_i,
	input  logic [`PU_ARCHBITSZ-1:0] wdata_i
);

	logic [`PU_ARCHBITSZ-1:0] regs [`PU_GPRCNT];

	assign rdata_a_o = regs[raddr_a_i];
	assign rdata_b_o = regs[raddr_b_i];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < `PU_GPRCNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[waddr_i] <= wdata_i;
		end
	end

endmodule

//--- design/pu_alu.sv
/* single cycle ALU
   add, sub, logic ops and shifts on the rd and rs values */
`include "pu_settings.svh"

module pu_alu (
	input  pu_pkg::opcode_t          op_i,
	input  logic [`PU_ARCHBITSZ-1:0] a_i,
	input  logic [`PU_ARCHBITSZ-1:0] b_i,
	output logic [`PU_ARCHBITSZ-1:0] result_o
);

	localparam int SHAMTSZ = $clog2(`PU_ARCHBITSZ);

	logic [SHAMTSZ-1:0] shamt;

	assign shamt = b_i[SHAMTSZ-1:0]; // low bits of rs only

	always_comb begin
		case (op_i)
			pu_pkg::OP_ADD: begin
				result_o = a_i + b_i;
			end
			pu_pkg::OP_SUB: begin
				result_o = a_i - b_i;
			end
			pu_pkg::OP_AND: begin
				result_o = a_i & b_i;
			end
			pu_pkg::OP_OR: begin
				result_o = a_i | b_i;
			end
			pu_pkg::OP_XOR: begin
				result_o = a_i ^ b_i;
			end
			pu_pkg::OP_SHL: begin
				result_o = a_i << shamt;
			end
			pu_pkg::OP_SHR: begin
				result_o = a_i >> shamt; // logical
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

//--- design/pu_muldiv.sv
/* iterative unsigned multiply and divide
   shift-and-add multiplier and restoring divider on one shared accumulator */
`include "pu_settings.svh"

module pu_muldiv (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     start_i,
	input  logic                     div_i,
	input  logic [`PU_ARCHBITSZ-1:0] a_i,
	input  logic [`PU_ARCHBITSZ-1:0] b_i,
	output logic [`PU_ARCHBITSZ-1:0] result_o,
	output logic                     done_o
);

	localparam int W     = `PU_ARCHBITSZ;
	localparam int CNTSZ = $clog2(`PU_MULDIVCNT + 1);

	logic             busy;
	logic [CNTSZ-1:0] cnt;
	logic             div_q;
	logic [W-1:0]     b_q;
	logic [W-1:0]     hi;  // partial product or remainder
	logic [W-1:0]     lo;  // multiplier bits, then quotient bits
	logic [W:0]       mul_sum;
	logic [W:0]       div_shl;
	logic [W:0]       div_diff;
	logic             div_ok;

	always_comb begin
		mul_sum  = {1'b0, hi} + {1'b0, (lo[0] ? b_q : {W{1'b0}})};
		div_shl  = {hi, lo[W-1]};
		div_diff = div_shl - {1'b0, b_q};
		div_ok   = (div_shl >= {1'b0, b_q}); // always true for b == 0, so all ones
	end

	assign result_o = lo;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy   <= 1'b0;
			cnt    <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				busy <= 1'b1;
				cnt  <= CNTSZ'(`PU_MULDIVCNT);
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				if (cnt == CNTSZ'(1)) begin
					busy   <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i) begin
			hi    <= '0;
			lo    <= a_i;
			b_q   <= b_i;
			div_q <= div_i;
		end else if (busy) begin
			if (div_q) begin
				hi <= div_ok ? div_diff[W-1:0] : div_shl[W-1:0];
				lo <= {lo[W-2:0], div_ok};
			end else begin
				{hi, lo} <= {mul_sum, lo[W-1:1]}; // shift right with carry
			end
		end
	end

endmodule

//--- design/pu_memctrl.sv
/* pi1 bus master
   holds a request on the bus until ready, then returns read data and a done pulse */
`include "pu_settings.svh"

module pu_memctrl (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     req_i,
	input  pu_pkg::memop_t           op_i,
	input  logic [`PU_ARCHBITSZ-1:0] addr_i,
	input  logic [`PU_ARCHBITSZ-1:0] wdata_i,
	output logic                     done_o,
	output logic [`PU_ARCHBITSZ-1:0] rdata_o,
	output pu_pkg::memop_t           pi1_op_o,
	output logic [`PU_ARCHBITSZ-1:0] pi1_addr_o,
	output logic [`PU_ARCHBITSZ-1:0] pi1_data_o,
	input  logic [`PU_ARCHBITSZ-1:0] pi1_data_i,
	input  logic                     pi1_rdy_i
);

	logic busy;
	logic accept;

	assign busy   = (pi1_op_o != pu_pkg::MEMNOOP);
	assign accept = req_i && !busy;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pi1_op_o <= pu_pkg::MEMNOOP;
			done_o   <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (busy) begin
				if (pi1_rdy_i) begin // transfer completes this cycle
					pi1_op_o <= pu_pkg::MEMNOOP;
					done_o   <= 1'b1;
				end
			end else if (req_i) begin
				pi1_op_o <= op_i;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			pi1_addr_o <= addr_i;
			pi1_data_o <= wdata_i;
		end
		if (pi1_op_o == pu_pkg::MEMREADOP && pi1_rdy_i) begin
			rdata_o <= pi1_data_i;
		end
	end

endmodule

//--- design/pu_sequencer.sv
/* fetch, decode and execute control
   program counter, instruction register, write-back select, halt and interrupts */
`include "pu_settings.svh"

module pu_sequencer (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic [`PU_ARCHBITSZ-1:0] rstaddr_i,
	input  logic [`PU_ARCHBITSZ-1:0] id_i,
	input  logic                     intrqst_i,
	output logic                     intrdy_o,
	output logic                     halted_o,
	output logic [`PU_ARCHBITSZ-1:0] pc_o,
	output logic                     mem_req_o,
	output pu_pkg::memop_t           mem_op_o,
	output logic [`PU_ARCHBITSZ-1:0] mem_addr_o,
	output logic [`PU_ARCHBITSZ-1:0] mem_wdata_o,
	input  logic                     mem_done_i,
	input  logic [`PU_ARCHBITSZ-1:0] mem_rdata_i,
	output logic [`PU_GPRIDXSZ-1:0]  gpr_ra_o,
	output logic [`PU_GPRIDXSZ-1:0]  gpr_rb_o,
	input  logic [`PU_ARCHBITSZ-1:0] gpr_rdata_a_i,
	input  logic [`PU_ARCHBITSZ-1:0] gpr_rdata_b_i,
	output logic                     gpr_we_o,
	output logic [`PU_GPRIDXSZ-1:0]  gpr_waddr_o,
	output logic [`PU_ARCHBITSZ-1:0] gpr_wdata_o,
	output pu_pkg::opcode_t          alu_op_o,
	input  logic [`PU_ARCHBITSZ-1:0] alu_result_i,
	output logic                     md_start_o,
	output logic                     md_div_o,
	input  logic [`PU_ARCHBITSZ-1:0] md_result_i,
	input  logic                     md_done_i
);

	localparam int W = `PU_ARCHBITSZ;
	localparam logic [`PU_GPRIDXSZ-1:0] LINKREG = `PU_GPRIDXSZ'(`PU_GPRCNT - 1); // r15
	localparam logic [W-1:0] INTRVECTOR = W'(`PU_INTRVECTOR);

	pu_pkg::seqstate_t         state;
	pu_pkg::opcode_t           op;
	logic [W-1:0]              pc;
	logic [W-1:0]              pc_next;
	logic [W-1:0]              ir;
	logic [W-1:0]              imm_sx;
	logic [`PU_GPRIDXSZ-1:0]   rd;
	logic [`PU_GPRIDXSZ-1:0]   rs;
	logic                      ie;       // interrupt enable
	logic                      take_intr;

	// instruction fields
	assign op      = pu_pkg::opcode_t'(ir[W-1 -: 4]);
	assign rd      = ir[W-5 -: `PU_GPRIDXSZ];
	assign rs      = ir[W-9 -: `PU_GPRIDXSZ];
	assign imm_sx  = {{(W - `PU_IMMSZ){ir[`PU_IMMSZ-1]}}, ir[`PU_IMMSZ-1:0]};
	assign pc_next = pc + 1'b1;

	// only at an instruction boundary
	assign take_intr = ie && intrqst_i &&
		(state == pu_pkg::SEQ_FETCH || state == pu_pkg::SEQ_HALT);

	assign intrdy_o = ie;
	assign halted_o = (state == pu_pkg::SEQ_HALT);
	assign pc_o     = pc;
	assign alu_op_o = op;
	assign md_div_o = (op == pu_pkg::OP_DIVU);
	assign gpr_ra_o = rd;
	assign gpr_rb_o = (op == pu_pkg::OP_RTI) ? LINKREG : rs;

	always_comb begin
		mem_req_o   = 1'b0;
		mem_op_o    = pu_pkg::MEMNOOP;
		mem_addr_o  = pc;
		mem_wdata_o = gpr_rdata_a_i; // st sends rd
		md_start_o  = 1'b0;
		gpr_we_o    = 1'b0;
		gpr_waddr_o = rd;
		gpr_wdata_o = alu_result_i;
		case (state)
			pu_pkg::SEQ_FETCH: begin
				if (take_intr) begin
					gpr_we_o    = 1'b1;
					gpr_waddr_o = LINKREG;
					gpr_wdata_o = pc; // already the next instruction
				end else begin
					mem_req_o = 1'b1;
					mem_op_o  = pu_pkg::MEMREADOP;
				end
			end
			pu_pkg::SEQ_HALT: begin
				if (take_intr) begin
					gpr_we_o    = 1'b1;
					gpr_waddr_o = LINKREG;
					gpr_wdata_o = pc_next; // resume after the halt
				end
			end
			pu_pkg::SEQ_EXEC: begin
				case (op)
					pu_pkg::OP_ADD, pu_pkg::OP_SUB, pu_pkg::OP_AND, pu_pkg::OP_OR,
					pu_pkg::OP_XOR, pu_pkg::OP_SHL, pu_pkg::OP_SHR: begin
						gpr_we_o = 1'b1;
					end
					pu_pkg::OP_LI: begin
						gpr_we_o    = 1'b1;
						gpr_wdata_o = imm_sx;
					end
					pu_pkg::OP_GETID: begin
						gpr_we_o    = 1'b1;
						gpr_wdata_o = id_i;
					end
					pu_pkg::OP_MUL, pu_pkg::OP_DIVU: begin
						md_start_o = 1'b1;
					end
					pu_pkg::OP_LD: begin
						mem_req_o  = 1'b1;
						mem_op_o   = pu_pkg::MEMREADOP;
						mem_addr_o = gpr_rdata_b_i;
					end
					pu_pkg::OP_ST: begin
						mem_req_o  = 1'b1;
						mem_op_o   = pu_pkg::MEMWRITEOP;
						mem_addr_o = gpr_rdata_b_i;
					end
					default: begin
					end
				endcase
			end
			pu_pkg::SEQ_MDWAIT: begin
				gpr_we_o    = md_done_i;
				gpr_wdata_o = md_result_i;
			end
			pu_pkg::SEQ_MEMWAIT: begin
				gpr_we_o    = mem_done_i && (op == pu_pkg::OP_LD);
				gpr_wdata_o = mem_rdata_i;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= pu_pkg::SEQ_FETCH;
			pc    <= rstaddr_i;
			ie    <= 1'b0;
		end else begin
			case (state)
				pu_pkg::SEQ_FETCH: begin
					if (take_intr) begin
						pc <= INTRVECTOR;
						ie <= 1'b0;
					end else begin
						state <= pu_pkg::SEQ_FWAIT;
					end
				end
				pu_pkg::SEQ_FWAIT: begin
					if (mem_done_i) state <= pu_pkg::SEQ_DECODE;
				end
				pu_pkg::SEQ_DECODE: begin
					state <= pu_pkg::SEQ_EXEC;
				end
				pu_pkg::SEQ_EXEC: begin
					case (op)
						pu_pkg::OP_MUL, pu_pkg::OP_DIVU: state <= pu_pkg::SEQ_MDWAIT;
						pu_pkg::OP_LD, pu_pkg::OP_ST: state <= pu_pkg::SEQ_MEMWAIT;
						pu_pkg::OP_HALT: state <= pu_pkg::SEQ_HALT; // pc stays on the halt
						pu_pkg::OP_JZ: begin
							pc    <= (gpr_rdata_a_i == '0) ? gpr_rdata_b_i : pc_next;
							state <= pu_pkg::SEQ_FETCH;
						end
						pu_pkg::OP_RTI: begin
							pc    <= gpr_rdata_b_i;
							ie    <= 1'b1;
							state <= pu_pkg::SEQ_FETCH;
						end
						default: begin
							pc    <= pc_next;
							state <= pu_pkg::SEQ_FETCH;
						end
					endcase
				end
				pu_pkg::SEQ_MDWAIT: begin
					if (md_done_i) begin
						pc    <= pc_next;
						state <= pu_pkg::SEQ_FETCH;
					end
				end
				pu_pkg::SEQ_MEMWAIT: begin
					if (mem_done_i) begin
						pc    <= pc_next;
						state <= pu_pkg::SEQ_FETCH;
					end
				end
				pu_pkg::SEQ_HALT: begin
					if (take_intr) begin
						pc    <= INTRVECTOR;
						ie    <= 1'b0;
						state <= pu_pkg::SEQ_FETCH;
					end
				end
				default: begin
					state <= pu_pkg::SEQ_FETCH;
				end
			endcase
		end
	end

	// instruction register
	always_ff @(posedge clk_i) begin
		if (state == pu_pkg::SEQ_FWAIT && mem_done_i) ir <= mem_rdata_i;
	end

endmodule

//--- design/pu.sv
/* processing unit top level
   sequencer with register file, ALU, multiply/divide and pi1 bus master */
`include "pu_settings.svh"

module pu (
	input  logic                     clk_i,
	input  logic                     rst_i,
	output pu_pkg::memop_t           pi1_op_o,
	output logic [`PU_ARCHBITSZ-1:0] pi1_addr_o,
	output logic [`PU_ARCHBITSZ-1:0] pi1_data_o,
	input  logic [`PU_ARCHBITSZ-1:0] pi1_data_i,
	input  logic                     pi1_rdy_i,
	input  logic                     intrqst_i,
	output logic                     intrdy_o,
	output logic                     halted_o,
	input  logic [`PU_ARCHBITSZ-1:0] rstaddr_i,
	input  logic [`PU_ARCHBITSZ-1:0] id_i,
	output logic [`PU_ARCHBITSZ-1:0] pc_o
);

	logic                     mem_req;
	pu_pkg::memop_t           mem_op;
	logic [`PU_ARCHBITSZ-1:0] mem_addr;
	logic [`PU_ARCHBITSZ-1:0] mem_wdata;
	logic                     mem_done;
	logic [`PU_ARCHBITSZ-1:0] mem_rdata;

	logic [`PU_GPRIDXSZ-1:0]  gpr_ra;
	logic [`PU_GPRIDXSZ-1:0]  gpr_rb;
	logic [`PU_ARCHBITSZ-1:0] gpr_rdata_a; // rd value
	logic [`PU_ARCHBITSZ-1:0] gpr_rdata_b; // rs value
	logic                     gpr_we;
	logic [`PU_GPRIDXSZ-1:0]  gpr_waddr;
	logic [`PU_ARCHBITSZ-1:0] gpr_wdata;

	pu_pkg::opcode_t          alu_op;
	logic [`PU_ARCHBITSZ-1:0] alu_result;

	logic                     md_start;
	logic                     md_div;
	logic [`PU_ARCHBITSZ-1:0] md_result;
	logic                     md_done;

	pu_sequencer u_seq (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.rstaddr_i     (rstaddr_i),
		.id_i          (id_i),
		.intrqst_i     (intrqst_i),
		.intrdy_o      (intrdy_o),
		.halted_o      (halted_o),
		.pc_o          (pc_o),
		.mem_req_o     (mem_req),
		.mem_op_o      (mem_op),
		.mem_addr_o    (mem_addr),
		.mem_wdata_o   (mem_wdata),
		.mem_done_i    (mem_done),
		.mem_rdata_i   (mem_rdata),
		.gpr_ra_o      (gpr_ra),
		.gpr_rb_o      (gpr_rb),
		.gpr_rdata_a_i (gpr_rdata_a),
		.gpr_rdata_b_i (gpr_rdata_b),
		.gpr_we_o      (gpr_we),
		.gpr_waddr_o   (gpr_waddr),
		.gpr_wdata_o   (gpr_wdata),
		.alu_op_o      (alu_op),
		.alu_result_i  (alu_result),
		.md_start_o    (md_start),
		.md_div_o      (md_div),
		.md_result_i   (md_result),
		.md_done_i     (md_done)
	);

	pu_gpr u_gpr (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.raddr_a_i (gpr_ra),
		.raddr_b_i (gpr_rb),
		.rdata_a_o (gpr_rdata_a),
		.rdata_b_o (gpr_rdata_b),
		.we_i      (gpr_we),
		.waddr_i   (gpr_waddr),
		.wdata_i   (gpr_wdata)
	);

	pu_alu u_alu (
		.op_i     (alu_op),
		.a_i      (gpr_rdata_a),
		.b_i      (gpr_rdata_b),
		.result_o (alu_result)
	);

	pu_muldiv u_muldiv (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.start_i  (md_start),
		.div_i    (md_div),
		.a_i      (gpr_rdata_a),
		.b_i      (gpr_rdata_b),
		.result_o (md_result),
		.done_o   (md_done)
	);

	pu_memctrl u_memctrl (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.req_i      (mem_req),
		.op_i       (mem_op),
		.addr_i     (mem_addr),
		.wdata_i    (mem_wdata),
		.done_o     (mem_done),
		.rdata_o    (mem_rdata),
		.pi1_op_o   (pi1_op_o),
		.pi1_addr_o (pi1_addr_o),
		.pi1_data_o (pi1_data_o),
		.pi1_data_i (pi1_data_i),
		.pi1_rdy_i  (pi1_rdy_i)
	);

endmodule

//--- bench/pu_tb.sv
/* processing unit testbench
   random programs checked against a reference model, memory with random wait states */
`include "pu_settings.svh"

module pu_tb;

	localparam int W        = `PU_ARCHBITSZ;
	localparam int MEMSZ    = 1024;
	localparam int TIMEOUT  = 5000;
	localparam int DATABASE = 'h200;
	localparam int DUMPBASE = 'h300;
	localparam int MIX_MD   = 1;
	localparam int MIX_MEM  = 2;

	logic           clk_i;
	logic           rst_i;
	pu_pkg::memop_t pi1_op;
	logic [W-1:0]   pi1_addr;
	logic [W-1:0]   pi1_wdata;
	logic [W-1:0]   pi1_rdata;
	logic           pi1_rdy;
	logic           intrqst;
	logic           intrdy;
	logic           halted;
	logic [W-1:0]   rstaddr;
	logic [W-1:0]   id;
	logic [W-1:0]   pc;

	logic [W-1:0] mem [MEMSZ];     // what the DUT sees on pi1
	logic [W-1:0] ref_mem [MEMSZ]; // model copy
	logic [W-1:0] ref_regs [16];
	int gen_pos;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	pu u_dut (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.pi1_op_o   (pi1_op),
		.pi1_addr_o (pi1_addr),
		.pi1_data_o (pi1_wdata),
		.pi1_data_i (pi1_rdata),
		.pi1_rdy_i  (pi1_rdy),
		.intrqst_i  (intrqst),
		.intrdy_o   (intrdy),
		.halted_o   (halted),
		.rstaddr_i  (rstaddr),
		.id_i       (id),
		.pc_o       (pc)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// memory model, 0 to 3 wait cycles per transfer
	initial begin : bus_memory
		int wait_cycles;
		pi1_rdy   = 1'b0;
		pi1_rdata = '0;
		forever begin
			@(negedge clk_i);
			pi1_rdy = 1'b0;
			if (!rst_i && pi1_op != pu_pkg::MEMNOOP) begin
				wait_cycles = $urandom_range(3, 0);
				repeat (wait_cycles) @(negedge clk_i);
				if (!rst_i && pi1_op == pu_pkg::MEMREADOP) begin
					pi1_rdata = mem[pi1_addr[9:0]];
					pi1_rdy   = 1'b1;
				end else if (!rst_i && pi1_op == pu_pkg::MEMWRITEOP) begin
					mem[pi1_addr[9:0]] = pi1_wdata;
					pi1_rdy = 1'b1;
				end
			end
		end
	end

	function automatic logic [W-1:0] enc(pu_pkg::opcode_t op, int rd, int rs, logic [W-1:0] imm);
		return {op, 4'(rd), 4'(rs), 4'b0000, imm[15:0]};
	endfunction

	function automatic int rand_reg();
		return $urandom_range(14, 0); // r15 stays free for dumps and links
	endfunction

	function automatic void emit(logic [W-1:0] word);
		mem[gen_pos] = word;
		gen_pos++;
	endfunction

	task automatic check_value(input string what, input logic [W-1:0] got,
		input logic [W-1:0] exp);
		assert (got === exp) else begin
			$display("error %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic fill_memory();
		int i;
		for (i = 0; i < MEMSZ; i++) begin
			mem[i] = (i * 32'h0101_0101) ^ 32'hc3a5_5a3c;
		end
	endtask

	task automatic gen_alu();
		emit(enc(pu_pkg::opcode_t'($urandom_range(7, 1)), rand_reg(), rand_reg(), 0));
	endtask

	task automatic gen_program(input int mix, input int body_len);
		int n;
		int r;
		int pick;
		int rd;
		int ra;
		int skip;
		int zero;
		gen_pos = 0;
		for (r = 0; r < 15; r++) begin
			emit(enc(pu_pkg::OP_LI, r, 0, $urandom()));
		end
		for (n = 0; n < body_len; n++) begin
			pick = $urandom_range(7, 0);
			rd   = rand_reg();
			ra   = (rd + 1 + $urandom_range(13, 0)) % 15; // never rd
			if ((mix & MIX_MD) && pick >= 5) begin
				if ($urandom_range(1, 0)) begin
					emit(enc(pu_pkg::OP_MUL, rd, ra, 0));
				end else begin
					if ($urandom_range(3, 0) == 0) emit(enc(pu_pkg::OP_LI, ra, 0, 0));
					emit(enc(pu_pkg::OP_DIVU, rd, ra, 0));
				end
			end else if ((mix & MIX_MEM) && pick == 5) begin
				emit(enc(pu_pkg::OP_LI, ra, 0, DATABASE + $urandom_range(31, 0)));
				if ($urandom_range(1, 0)) emit(enc(pu_pkg::OP_LD, rd, ra, 0));
				else emit(enc(pu_pkg::OP_ST, rd, ra, 0));
			end else if ((mix & MIX_MEM) && pick == 6) begin
				zero = $urandom_range(1, 0);
				skip = $urandom_range(3, 1);
				// target lies just past the skipped ALU words
				emit(enc(pu_pkg::OP_LI, ra, 0, gen_pos + 2 + zero + skip));
				if (zero) emit(enc(pu_pkg::OP_LI, rd, 0, 0));
				emit(enc(pu_pkg::OP_JZ, rd, ra, 0));
				repeat (skip) gen_alu();
			end else if ((mix & MIX_MEM) && pick == 7) begin
				emit(enc(pu_pkg::OP_GETID, rd, 0, 0));
			end else if (pick == 4) begin
				emit(enc(pu_pkg::OP_LI, rd, 0, ($urandom_range(3, 0) == 0) ? 0 : $urandom()));
			end else begin
				gen_alu();
			end
		end
		// register dump
		for (r = 0; r < 15; r++) begin
			emit(enc(pu_pkg::OP_LI, 15, 0, DUMPBASE + r));
			emit(enc(pu_pkg::OP_ST, r, 15, 0));
		end
		emit(enc(pu_pkg::OP_HALT, 0, 0, 0));
	endtask

	task automatic run_model(output logic [W-1:0] halt_pc, output bit ok);
		logic [W-1:0] mpc;
		logic [W-1:0] next;
		logic [W-1:0] word;
		logic [W-1:0] imm;
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic [3:0]   rd;
		logic [3:0]   rs;
		int           steps;
		int           r;
		mpc     = rstaddr;
		ok      = 1'b0;
		halt_pc = '0;
		for (r = 0; r < 16; r++) begin
			ref_regs[r] = '0;
		end
		for (steps = 0; steps < 20000 && !ok; steps++) begin
			word = ref_mem[mpc[9:0]];
			rd   = word[27:24];
			rs   = word[23:20];
			imm  = {{16{word[15]}}, word[15:0]};
			a    = ref_regs[rd];
			b    = ref_regs[rs];
			next = mpc + 1;
			case (pu_pkg::opcode_t'(word[31:28]))
				pu_pkg::OP_LI:    ref_regs[rd] = imm;
				pu_pkg::OP_ADD:   ref_regs[rd] = a + b;
				pu_pkg::OP_SUB:   ref_regs[rd] = a - b;
				pu_pkg::OP_AND:   ref_regs[rd] = a & b;
				pu_pkg::OP_OR:    ref_regs[rd] = a | b;
				pu_pkg::OP_XOR:   ref_regs[rd] = a ^ b;
				pu_pkg::OP_SHL:   ref_regs[rd] = a << b[4:0];
				pu_pkg::OP_SHR:   ref_regs[rd] = a >> b[4:0];
				pu_pkg::OP_MUL:   ref_regs[rd] = a * b;
				pu_pkg::OP_DIVU:  ref_regs[rd] = (b == 0) ? '1 : a / b;
				pu_pkg::OP_LD:    ref_regs[rd] = ref_mem[b[9:0]];
				pu_pkg::OP_ST:    ref_mem[b[9:0]] = a;
				pu_pkg::OP_JZ:    next = (a == 0) ? b : next;
				pu_pkg::OP_GETID: ref_regs[rd] = id;
				pu_pkg::OP_RTI:   next = ref_regs[15];
				pu_pkg::OP_HALT: begin
					halt_pc = mpc;
					ok      = 1'b1;
				end
			endcase
			if (!ok) mpc = next;
		end
		if (!ok) begin
			$display("the reference model did not reach a halt instruction");
			errors++;
		end
	endtask

	task automatic do_reset();
		@(negedge clk_i);
		rst_i = 1'b1;
		repeat (3) @(negedge clk_i);
		check_value("bus op in reset", W'(pi1_op), W'(pu_pkg::MEMNOOP));
		check_value("halted_o in reset", W'(halted), '0);
		check_value("intrdy_o in reset", W'(intrdy), '0);
		rst_i = 1'b0;
	endtask

	task automatic wait_halt(output bit ok);
		int cycles;
		cycles = 0;
		while (!halted && cycles < TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
		end
		ok = halted;
		if (!ok) begin
			$display("timeout: the unit did not halt within %0d cycles", TIMEOUT);
			errors++;
		end
	endtask

	task automatic wait_bus_op(output int cycles, output bit ok);
		cycles = 0;
		while (pi1_op == pu_pkg::MEMNOOP && cycles < TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
		end
		ok = (pi1_op != pu_pkg::MEMNOOP);
		if (!ok) begin
			$display("timeout: no bus operation within %0d cycles", TIMEOUT);
			errors++;
		end
	endtask

	task automatic run_random_program(input int mix, input int body_len,
		output logic [W-1:0] halt_pc);
		bit ok;
		int i;
		fill_memory();
		gen_program(mix, body_len);
		ref_mem = mem;
		rstaddr = '0;
		id      = $urandom();
		run_model(halt_pc, ok);
		do_reset();
		wait_halt(ok);
		if (ok) begin
			check_value("halt pc", pc, halt_pc);
			for (i = 0; i < MEMSZ; i++) begin
				check_value($sformatf("memory word %h", i), mem[i], ref_mem[i]);
			end
		end
	endtask

	task automatic end_test(input int num, input string name);
		tests_run++;
		if (errors == test_errors) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	initial begin : main
		int           cycles;
		int           r;
		bit           ok;
		logic [W-1:0] halt_pc;
		logic [W-1:0] halt_at;
		void'($urandom(71));
		rst_i        = 1'b1;
		intrqst      = 1'b0;
		rstaddr      = '0;
		id           = '0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;

		// reset state and first fetch from rstaddr_i
		fill_memory();
		rstaddr = W'($urandom_range('hf0, 'h10));
		mem[rstaddr[9:0]] = enc(pu_pkg::OP_HALT, 0, 0, 0);
		do_reset();
		wait_bus_op(cycles, ok);
		if (ok) begin
			check_value("first bus op", W'(pi1_op), W'(pu_pkg::MEMREADOP));
			check_value("first fetch address", pi1_addr, rstaddr);
			check_value("cycles to first fetch", cycles, 1);
		end
		wait_halt(ok);
		if (ok) check_value("halt pc", pc, rstaddr);
		end_test(1, "reset and first fetch");

		repeat (4) run_random_program(0, 40, halt_pc);
		end_test(2, "alu and li");

		repeat (4) run_random_program(MIX_MD, 30, halt_pc);
		end_test(3, "mul and divu");

		repeat (4) run_random_program(MIX_MEM, 40, halt_pc);
		end_test(4, "ld st jz getid");

		// interrupts stay disabled after reset
		run_random_program(0, 10, halt_pc);
		check_value("intrdy_o while halted", W'(intrdy), '0);
		intrqst = 1'b1;
		repeat (50) begin
			@(negedge clk_i);
			check_value("halted_o under request", W'(halted), 1);
			check_value("pc under request", pc, halt_pc);
			check_value("bus op under request", W'(pi1_op), W'(pu_pkg::MEMNOOP));
		end
		intrqst = 1'b0;
		end_test(5, "halt with interrupts disabled");

		// rti enables interrupts, then the handler dumps r15
		fill_memory();
		gen_pos = 0;
		for (r = 0; r < 15; r++) begin
			emit(enc(pu_pkg::OP_LI, r, 0, $urandom()));
		end
		repeat (6) gen_alu();
		halt_at = gen_pos + 2;
		emit(enc(pu_pkg::OP_LI, 15, 0, halt_at));
		emit(enc(pu_pkg::OP_RTI, 0, 0, 0));
		emit(enc(pu_pkg::OP_HALT, 0, 0, 0));
		gen_pos = `PU_INTRVECTOR;
		emit(enc(pu_pkg::OP_LI, 14, 0, DUMPBASE));
		emit(enc(pu_pkg::OP_ST, 15, 14, 0));
		emit(enc(pu_pkg::OP_HALT, 0, 0, 0));
		rstaddr = '0;
		do_reset();
		wait_halt(ok);
		if (ok) begin
			check_value("pc at first halt", pc, halt_at);
			check_value("intrdy_o after rti", W'(intrdy), 1);
			intrqst = 1'b1;
			wait_bus_op(cycles, ok);
			intrqst = 1'b0;
			if (ok) begin
				check_value("bus op after interrupt", W'(pi1_op), W'(pu_pkg::MEMREADOP));
				check_value("fetch after interrupt", pi1_addr, W'(`PU_INTRVECTOR));
			end
			wait_halt(ok);
			if (ok) begin
				check_value("pc at handler halt", pc, W'(`PU_INTRVECTOR + 2));
				check_value("intrdy_o in handler", W'(intrdy), '0);
				check_value("dumped r15", mem[DUMPBASE], halt_at + 1);
			end
		end
		end_test(6, "interrupt from halt");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+design
design/pu_pkg.sv
design/pu_gpr.sv
design/pu_alu.sv
design/pu_muldiv.sv
design/pu_memctrl.sv
design/pu_sequencer.sv
design/pu.sv
bench/pu_tb.sv
